// ==== rtl/bpcorr_consts.svh ====
`ifndef BPCORR_CONSTS_SVH
`define BPCORR_CONSTS_SVH

// Probe bank and engine count
`define BPCORR_N_PROBE      4   // Single-bit probes sampled together
`define BPCORR_N_ENGINE     2   // Correlation engines, one PWM each
`define BPCORR_PROBE_IDX_W  2   // Wide enough to index every probe

// Configuration bus
`define BPCORR_CFG_W        16  // Config word
`define BPCORR_ADDR_W       2   // Global word plus one per engine

// Result and display
`define BPCORR_FRAC_W       16  // Fraction of window, full scale 65535
`define BPCORR_PWM_W        8   // 256 cycles per PWM period

// Longest window is 2^10 samples
`define BPCORR_MAX_WIN_EXP  10

`endif

// ==== rtl/bpcorr_metric_pkg.sv ====
`include "bpcorr_consts.svh"

package bpcorr_metric_pkg;

  // Relation evaluated between probe X and probe Y on each sample
  typedef enum logic [1:0] {
    METRIC_AGREE    = 2'd0, // X == Y
    METRIC_COINCIDE = 2'd1, // X and Y both high
    METRIC_X_ONLY   = 2'd2, // X high, Y low
    METRIC_OFF      = 2'd3  // Never hits
  } metric_sel_e;

  // Hit count scaled to the window, 0xffff means every sample hit
  typedef logic [`BPCORR_FRAC_W-1:0] frac_t;

endpackage

// ==== rtl/bpcorr_cfg_pkg.sv ====
`include "bpcorr_consts.svh"

package bpcorr_cfg_pkg;

  import bpcorr_metric_pkg::*;

  // Word at address 0, first field is the MSB
  typedef struct packed {
    logic [3:0] reserved; // Ignored on write
    logic [7:0] period;   // Sample period minus one
    logic [3:0] win_exp;  // Window is 2^win_exp samples
  } global_cfg_s;

  // Word at address 1 + engine index
  typedef struct packed {
    logic [8:0]                     reserved; // Ignored
    metric_sel_e                    metric;   // Relation to count
    logic [`BPCORR_PROBE_IDX_W-1:0] y_idx;    // Probe Y select
    logic [`BPCORR_PROBE_IDX_W-1:0] x_idx;    // Probe X select
    logic                           enable;   // Engine running
  } engine_cfg_s;

  // Same 16 bits, view picked by the address
  typedef union packed {
    global_cfg_s glob;
    engine_cfg_s eng;
  } cfg_word_u;

  typedef logic [`BPCORR_ADDR_W-1:0] cfg_addr_t;

  localparam cfg_addr_t CFG_ADDR_GLOBAL = '0; // Engines follow at 1, 2, ...

endpackage

// ==== rtl/bpcorr_cfg_regs.sv ====
`include "bpcorr_consts.svh"

module bpcorr_cfg_regs (
  input  logic                                                i_clk_48MHz,
  input  logic                                                i_arst_n,
  input  logic                                                i_cfg_wr,
  input  bpcorr_cfg_pkg::cfg_addr_t                           i_cfg_addr,
  input  bpcorr_cfg_pkg::cfg_word_u                           i_cfg_wdata,
  output bpcorr_cfg_pkg::global_cfg_s                         o_global_cfg,
  output bpcorr_cfg_pkg::engine_cfg_s [`BPCORR_N_ENGINE-1:0]  o_engine_cfg,
  output logic                                                o_restart
);
  import bpcorr_cfg_pkg::*;
  import bpcorr_metric_pkg::*;

  global_cfg_s wr_global; // Incoming global word after clamping

  // Global view of the write data, window limited to the max
  always_comb begin
    wr_global          = i_cfg_wdata.glob;
    wr_global.reserved = '0;
    if (wr_global.win_exp > 4'(`BPCORR_MAX_WIN_EXP)) begin
      wr_global.win_exp = 4'(`BPCORR_MAX_WIN_EXP); // Clamp oversize window
    end
  end

  always_ff @(posedge i_clk_48MHz or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_global_cfg <= '{reserved: '0, period: 8'd0, win_exp: 4'd4}; // 16 samples, every clk
      for (int e = 0; e < `BPCORR_N_ENGINE; e++) begin
        o_engine_cfg[e] <= '{reserved: '0, metric: METRIC_OFF,
                             y_idx: '0, x_idx: '0, enable: 1'b0};
      end
    end else if (i_cfg_wr) begin
      if (i_cfg_addr == CFG_ADDR_GLOBAL) begin
        o_global_cfg <= wr_global;
      end
      for (int e = 0; e < `BPCORR_N_ENGINE; e++) begin
        if (i_cfg_addr == cfg_addr_t'(e + 1)) begin
          o_engine_cfg[e] <= i_cfg_wdata.eng; // Engine view of the same word
        end
      end
    end
  end

  // Restart everything the cycle after any write
  // so strobe phase and window boundaries line up again
  always_ff @(posedge i_clk_48MHz or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_restart <= 1'b0;
    end else begin
      o_restart <= i_cfg_wr; // Unmapped addresses restart too
    end
  end

endmodule

// ==== rtl/bpcorr_sample_strobe.sv ====
module bpcorr_sample_strobe (
  input  logic       i_clk_48MHz,
  input  logic       i_arst_n,
  input  logic       i_restart,
  input  logic [7:0] i_period,
  output logic       o_sample_stb
);

  logic [7:0] cnt;     // Cycles left until next strobe
  logic [7:0] cnt_nxt;

  // Reload on restart or on reaching zero, else count down
  always_comb begin
    if (i_restart || (cnt == 8'd0)) begin
      cnt_nxt = i_period;
    end else begin
      cnt_nxt = cnt - 8'd1;
    end
  end

  always_ff @(posedge i_clk_48MHz or negedge i_arst_n) begin
    if (!i_arst_n) begin
      cnt          <= 8'd0;
      o_sample_stb <= 1'b0;
    end else begin
      cnt          <= cnt_nxt;
      o_sample_stb <= (cnt_nxt == 8'd0); // High while counter sits at zero
    end
  end

endmodule

// ==== rtl/bpcorr_engine.sv ====
`include "bpcorr_consts.svh"

module bpcorr_engine (
  input  logic                         i_clk_48MHz,
  input  logic                         i_arst_n,
  input  logic                         i_restart,
  input  logic                         i_sample_stb,
  input  logic [`BPCORR_N_PROBE-1:0]   i_probe,
  input  logic [3:0]                   i_win_exp,
  input  bpcorr_cfg_pkg::engine_cfg_s  i_cfg,
  output bpcorr_metric_pkg::frac_t     o_frac
);
  import bpcorr_metric_pkg::*;

  localparam int CNT_W = `BPCORR_MAX_WIN_EXP + 1; // Holds a full window count

  logic             probe_x;
  logic             probe_y;
  logic             hit;         // Relation holds this sample
  logic [CNT_W-1:0] win_len;     // 2^k samples
  logic [CNT_W-1:0] smp_cnt;     // Samples taken in current window
  logic [CNT_W-1:0] hit_cnt;     // Hits so far in current window
  logic [CNT_W-1:0] hit_cnt_nxt; // Includes the sample on this strobe
  logic             win_done;    // Last strobe of the window
  logic [4:0]       frac_shift;  // FRAC_W - k
  frac_t            frac_nxt;

  // Probe pair mux
  assign probe_x = i_probe[i_cfg.x_idx];
  assign probe_y = i_probe[i_cfg.y_idx];

  always_comb begin
    case (i_cfg.metric)
      METRIC_AGREE:    hit = (probe_x == probe_y);
      METRIC_COINCIDE: hit = probe_x & probe_y;
      METRIC_X_ONLY:   hit = probe_x & ~probe_y;
      default:         hit = 1'b0; // METRIC_OFF
    endcase
  end

  assign win_len     = CNT_W'(1) << i_win_exp; // k clamped upstream, fits CNT_W
  assign hit_cnt_nxt = hit_cnt + CNT_W'(hit);
  assign win_done    = i_sample_stb && (smp_cnt == win_len - CNT_W'(1));

  // count * 2^16 / 2^k is just a left shift
  assign frac_shift = 5'(`BPCORR_FRAC_W) - 5'(i_win_exp);

  always_comb begin
    if (hit_cnt_nxt == win_len) begin
      frac_nxt = '1; // Every sample hit, saturate below 2^16
    end else begin
      frac_nxt = frac_t'(hit_cnt_nxt) << frac_shift;
    end
  end

  // Window counters
  always_ff @(posedge i_clk_48MHz or negedge i_arst_n) begin
    if (!i_arst_n) begin
      smp_cnt <= '0;
      hit_cnt <= '0;
    end else if (!i_cfg.enable || i_restart || win_done) begin
      smp_cnt <= '0; // Idle, restarted or window closing
      hit_cnt <= '0;
    end else if (i_sample_stb) begin
      smp_cnt <= smp_cnt + CNT_W'(1);
      hit_cnt <= hit_cnt_nxt;
    end
  end

  // Result register, updated once per window
  always_ff @(posedge i_clk_48MHz or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_frac <= '0;
    end else if (!i_cfg.enable) begin
      o_frac <= '0; // Disabled engine reads as zero
    end else if (win_done && !i_restart) begin
      o_frac <= frac_nxt; // Restart keeps last result
    end
  end

endmodule

// ==== rtl/bpcorr_pwm.sv ====
`include "bpcorr_consts.svh"

module bpcorr_pwm (
  input  logic                       i_clk_48MHz,
  input  logic                       i_arst_n,
  input  logic [`BPCORR_PWM_W-1:0]   i_duty,
  output logic                       o_pwm
);

  logic [`BPCORR_PWM_W-1:0] cnt;     // Free running period counter
  logic [`BPCORR_PWM_W-1:0] cnt_nxt;
  logic [`BPCORR_PWM_W-1:0] duty_q;  // Duty in force for this period

  assign cnt_nxt = cnt + 1'b1;

  always_ff @(posedge i_clk_48MHz or negedge i_arst_n) begin
    if (!i_arst_n) begin
      cnt    <= '0;
      duty_q <= '0;
      o_pwm  <= 1'b0;
    end else begin
      cnt <= cnt_nxt;
      if (cnt == '1) begin
        duty_q <= i_duty;          // New duty takes effect at count 0
        o_pwm  <= (i_duty != '0);
      end else begin
        o_pwm <= (cnt_nxt < duty_q); // High for duty_q counts per period
      end
    end
  end

endmodule

// ==== rtl/bpcorr_top.sv ====
`include "bpcorr_consts.svh"

module bpcorr_top (
  input  logic                          i_clk_48MHz,
  input  logic                          i_arst_n,
  input  logic                          i_cfg_wr,
  input  bpcorr_cfg_pkg::cfg_addr_t     i_cfg_addr,
  input  bpcorr_cfg_pkg::cfg_word_u     i_cfg_wdata,
  input  logic [`BPCORR_N_PROBE-1:0]    i_probe,
  output logic [`BPCORR_N_ENGINE-1:0]   o_pwm
);
  import bpcorr_cfg_pkg::*;
  import bpcorr_metric_pkg::*;

  global_cfg_s                         global_cfg;
  engine_cfg_s [`BPCORR_N_ENGINE-1:0]  engine_cfg;
  logic                                restart;    // Cycle after any write
  logic                                sample_stb; // Shared by all engines
  frac_t       [`BPCORR_N_ENGINE-1:0]  frac;

  bpcorr_cfg_regs u_cfg_regs (
    .i_clk_48MHz  (i_clk_48MHz),
    .i_arst_n     (i_arst_n),
    .i_cfg_wr     (i_cfg_wr),
    .i_cfg_addr   (i_cfg_addr),
    .i_cfg_wdata  (i_cfg_wdata),
    .o_global_cfg (global_cfg),
    .o_engine_cfg (engine_cfg),
    .o_restart    (restart)
  );

  bpcorr_sample_strobe u_sample_strobe (
    .i_clk_48MHz  (i_clk_48MHz),
    .i_arst_n     (i_arst_n),
    .i_restart    (restart),
    .i_period     (global_cfg.period),
    .o_sample_stb (sample_stb)
  );

  for (genvar e = 0; e < `BPCORR_N_ENGINE; e++) begin : g_engine
    bpcorr_engine u_engine (
      .i_clk_48MHz  (i_clk_48MHz),
      .i_arst_n     (i_arst_n),
      .i_restart    (restart),
      .i_sample_stb (sample_stb),
      .i_probe      (i_probe),
      .i_win_exp    (global_cfg.win_exp),
      .i_cfg        (engine_cfg[e]),
      .o_frac       (frac[e])
    );

    bpcorr_pwm u_pwm (
      .i_clk_48MHz  (i_clk_48MHz),
      .i_arst_n     (i_arst_n),
      .i_duty       (frac[e][`BPCORR_FRAC_W-1 -: `BPCORR_PWM_W]), // Top bits of fraction
      .o_pwm        (o_pwm[e])
    );
  end

endmodule

// ==== dv/bpcorr_tb.sv ====
`include "bpcorr_consts.svh"

module bpcorr_tb;
  timeunit 1ns;
  timeprecision 1ns;

  import bpcorr_cfg_pkg::*;
  import bpcorr_metric_pkg::*;

  localparam int          N_ROW    = 7;
  localparam int          SEED     = 32'h46868a46;
  localparam int          PWM_LEN  = 1 << `BPCORR_PWM_W; // Cycles per PWM period
  localparam logic [1:0]  MODE_LO  = 2'd0;               // Probe held low
  localparam logic [1:0]  MODE_HI  = 2'd1;               // Probe held high
  localparam logic [1:0]  MODE_TOG = 2'd2;               // Toggles every period+1 cycles
  localparam logic [1:0]  MODE_RND = 2'd3;               // Random constant for the row

  typedef struct packed {
    logic [3:0][1:0] mode;    // Mode per probe
    logic [3:0]      win_exp;
    logic [7:0]      period;
    engine_cfg_s     eng0;
    engine_cfg_s     eng1;
    logic [1:0][7:0] duty;    // Expected high cycles per engine
  } row_s;

  logic                         clk;
  logic                         arst_n;
  logic                         cfg_wr;
  cfg_addr_t                    cfg_addr;
  cfg_word_u                    cfg_wdata;
  logic [`BPCORR_N_PROBE-1:0]   probe;
  logic [`BPCORR_N_ENGINE-1:0]  pwm;

  row_s            tbl [N_ROW];
  logic [3:0][1:0] cur_mode;   // Probe modes in force
  logic [7:0]      cur_period;
  logic            cur_rnd;    // Value of every random-mode probe
  logic [7:0]      tog_cnt;
  logic            tog_val;
  int              hi_cnt [`BPCORR_N_ENGINE];
  int              cyc;
  int              cyc_limit;
  int              n_pass;
  int              n_fail;

  bpcorr_top i_dut (
    .i_clk_48MHz (clk),
    .i_arst_n    (arst_n),
    .i_cfg_wr    (cfg_wr),
    .i_cfg_addr  (cfg_addr),
    .i_cfg_wdata (cfg_wdata),
    .i_probe     (probe),
    .o_pwm       (pwm)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk; // 100 ns period
  end

  // Watchdog
  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= cyc_limit) begin
      $display("Timeout: no final result after %0d clock cycles", cyc);
      $display("Simulation failed");
      $finish;
    end
  end

  // Probe bank driver with square wave at the strobe period
  always @(posedge clk) begin
    if (tog_cnt >= cur_period) begin
      tog_cnt <= 8'd0;
      tog_val <= ~tog_val;
    end else begin
      tog_cnt <= tog_cnt + 8'd1;
    end
    for (int p = 0; p < `BPCORR_N_PROBE; p++) begin
      case (cur_mode[p])
        MODE_LO:  probe[p] <= 1'b0;
        MODE_HI:  probe[p] <= 1'b1;
        MODE_TOG: probe[p] <= tog_val;
        default:  probe[p] <= cur_rnd;
      endcase
    end
  end

  function automatic engine_cfg_s make_eng(input logic en, input logic [1:0] x,
                                           input logic [1:0] y, input metric_sel_e m);
    engine_cfg_s c;
    c        = '0;
    c.enable = en;
    c.x_idx  = x;
    c.y_idx  = y;
    c.metric = m;
    return c;
  endfunction

  // Three windows to settle plus one PWM period to latch the duty
  function automatic int row_wait(input row_s r);
    return 3 * (1 << r.win_exp) * (int'(r.period) + 1) + PWM_LEN;
  endfunction

  task automatic set_row(input int i, input logic [1:0] m3, input logic [1:0] m2,
                         input logic [1:0] m1, input logic [1:0] m0, input int k,
                         input int per, input engine_cfg_s e0, input engine_cfg_s e1,
                         input int d0, input int d1);
    tbl[i].mode    = {m3, m2, m1, m0};
    tbl[i].win_exp = k[3:0];
    tbl[i].period  = per[7:0];
    tbl[i].eng0    = e0;
    tbl[i].eng1    = e1;
    tbl[i].duty    = {d1[7:0], d0[7:0]};
  endtask

  task automatic write_cfg(input cfg_addr_t a, input cfg_word_u w);
    @(posedge clk);
    cfg_wr    <= 1'b1;
    cfg_addr  <= a;
    cfg_wdata <= w;
    @(posedge clk);
    cfg_wr    <= 1'b0;
  endtask

  // Counts high cycles of each PWM bit over one period at the negedge
  task automatic count_high();
    for (int e = 0; e < `BPCORR_N_ENGINE; e++) hi_cnt[e] = 0;
    repeat (PWM_LEN) begin
      @(negedge clk);
      for (int e = 0; e < `BPCORR_N_ENGINE; e++) hi_cnt[e] += int'(pwm[e]);
    end
  endtask

  task automatic check_duty(input int t, input string name, input int d0, input int d1);
    int errs;
    int exp_d;
    errs = 0;
    for (int e = 0; e < `BPCORR_N_ENGINE; e++) begin
      exp_d = (e == 0) ? d0 : d1;
      if (hi_cnt[e] != exp_d) begin
        $display("Error: t=%0t o_pwm[%0d] got %0d high cycles, expected %0d",
                 $time, e, hi_cnt[e], exp_d);
        errs++;
      end
    end
    if (errs == 0) begin
      n_pass++;
      $display("Test %0d %s: ok", t, name);
    end else begin
      n_fail++;
      $display("Test %0d %s: FAIL", t, name);
    end
  endtask

  initial begin
    cfg_word_u w;
    void'($urandom(SEED));
    arst_n     = 1'b0;
    cfg_wr     = 1'b0;
    cfg_addr   = '0;
    cfg_wdata  = '0;
    probe      = '0;
    cur_mode   = '0;
    cur_period = 8'd0;
    cur_rnd    = 1'b0;
    tog_cnt    = 8'd0;
    tog_val    = 1'b0;
    cyc        = 0;
    n_pass     = 0;
    n_fail     = 0;

    // Probe modes are given p3 first
    set_row(0, MODE_HI, MODE_TOG, MODE_RND, MODE_RND, 4, 0, make_eng(1, 0, 1, METRIC_AGREE),
            make_eng(1, 2, 3, METRIC_AGREE), 255, 128);
    set_row(1, MODE_TOG, MODE_LO, MODE_HI, MODE_HI, 2, 3, make_eng(1, 0, 1, METRIC_COINCIDE),
            make_eng(1, 0, 2, METRIC_COINCIDE), 255, 0);
    set_row(2, MODE_TOG, MODE_LO, MODE_HI, MODE_HI, 8, 0, make_eng(1, 3, 0, METRIC_COINCIDE),
            make_eng(1, 0, 1, METRIC_AGREE), 128, 255);
    set_row(3, MODE_RND, MODE_LO, MODE_LO, MODE_TOG, 4, 9, make_eng(1, 0, 1, METRIC_X_ONLY),
            make_eng(1, 2, 3, METRIC_X_ONLY), 128, 0);
    set_row(4, MODE_RND, MODE_RND, MODE_RND, MODE_RND, 2, 9, make_eng(1, 0, 1, METRIC_OFF),
            make_eng(1, 3, 3, METRIC_AGREE), 0, 255);
    set_row(5, MODE_HI, MODE_TOG, MODE_RND, MODE_RND, 8, 3, make_eng(1, 0, 1, METRIC_AGREE),
            make_eng(1, 2, 3, METRIC_AGREE), 255, 128);
    set_row(6, MODE_HI, MODE_TOG, MODE_RND, MODE_RND, 4, 3, make_eng(0, 0, 1, METRIC_AGREE),
            make_eng(1, 2, 3, METRIC_AGREE), 0, 128); // Engine 0 switched off

    cyc_limit = 16 + PWM_LEN + 8;
    for (int i = 0; i < N_ROW; i++) cyc_limit += row_wait(tbl[i]) + PWM_LEN + 16;
    cyc_limit = cyc_limit * 12 / 10; // 20 percent margin

    repeat (16) @(posedge clk);
    arst_n <= 1'b1;

    count_high(); // Nothing written yet
    check_duty(0, "after reset", 0, 0);

    for (int i = 0; i < N_ROW; i++) begin
      cur_mode   = tbl[i].mode; // Set at negedge, read by the probe driver at posedge
      cur_period = tbl[i].period;
      cur_rnd    = 1'($urandom % 2);
      w              = '0;
      w.glob.win_exp = tbl[i].win_exp;
      w.glob.period  = tbl[i].period;
      write_cfg(CFG_ADDR_GLOBAL, w);
      w     = '0;
      w.eng = tbl[i].eng0;
      write_cfg(cfg_addr_t'(1), w);
      w.eng = tbl[i].eng1;
      write_cfg(cfg_addr_t'(2), w);
      repeat (row_wait(tbl[i])) @(posedge clk);
      count_high();
      check_duty(i + 1, "table row", tbl[i].duty[0], tbl[i].duty[1]);
    end

    $display("Tests run: %0d, passed: %0d, failed: %0d", n_pass + n_fail, n_pass, n_fail);
    if (n_fail == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== bpcorr_top.f ====
+incdir+rtl
rtl/bpcorr_metric_pkg.sv
rtl/bpcorr_cfg_pkg.sv
rtl/bpcorr_cfg_regs.sv
rtl/bpcorr_sample_strobe.sv
rtl/bpcorr_engine.sv
rtl/bpcorr_pwm.sv
rtl/bpcorr_top.sv
dv/bpcorr_tb.sv
